// ==== hdl/exc_pkg.sv ====
/* shared types and constants of the exception unit
   vectors follow the x86 exception table; a stage record is only
   looked at while its fault bit is high */
package exc_pkg;

    // ----------------------------------------
    // exception vectors
    // ----------------------------------------
    localparam logic [7:0] vec_de = 8'd0;
    localparam logic [7:0] vec_db = 8'd1;
    localparam logic [7:0] vec_bp = 8'd3;
    localparam logic [7:0] vec_of = 8'd4;
    localparam logic [7:0] vec_br = 8'd5;
    localparam logic [7:0] vec_ud = 8'd6;
    localparam logic [7:0] vec_nm = 8'd7;
    localparam logic [7:0] vec_df = 8'd8;
    localparam logic [7:0] vec_ts = 8'd10;
    localparam logic [7:0] vec_np = 8'd11;
    localparam logic [7:0] vec_ss = 8'd12;
    localparam logic [7:0] vec_gp = 8'd13;
    localparam logic [7:0] vec_pf = 8'd14;
    localparam logic [7:0] vec_mc = 8'd18;
    localparam logic [7:0] vec_ac = 8'd17;

    // pipeline stages, oldest has the highest index
    localparam int num_stages = 4;
    localparam int stage_dec  = 0;
    localparam int stage_rd   = 1;
    localparam int stage_exe  = 2;
    localparam int stage_wr   = 3;

    // nested deliveries allowed before shutdown
    localparam int max_nesting = 2;

    typedef enum logic [1:0] {
        benign,
        contributory,
        page_fault,
        double_fault
    } fault_class_e;

    // ----------------------------------------
    // records
    // ----------------------------------------
    typedef struct packed {
        logic        fault;
        logic [7:0]  vector;
        logic [15:0] error_code;  // translation code for pf
        logic [31:0] eip;
        logic [3:0]  consumed;
    } stage_fault_t;

    typedef struct packed {
        logic [7:0]  vector;
        logic [15:0] error_code;
        logic [31:0] fault_eip;   // corrected pointer
        logic [31:0] trap_eip;    // raw stage pointer
        logic        valid;
    } fault_rec_t;

    // one-hot while a fault is pending, halted tracks shutdown
    typedef struct packed {
        logic deliver;
        logic to_double;
        logic to_shutdown;
        logic halted;
    } esc_decision_t;

    typedef struct packed {
        logic [7:0]  vector;
        logic [15:0] error_code;
        logic        push_error;
        logic [31:0] eip;
    } exc_frame_t;

endpackage

// ==== hdl/fault_arbiter.sv ====
/* oldest-stage fault capture
   new faults are ignored while a record is pending or after shutdown;
   the stage must hold its record stable in the cycle it faults */
module fault_arbiter (
    input  logic                   clk,
    input  logic                   rst_n,
    input  exc_pkg::stage_fault_t  stage_faults [exc_pkg::num_stages],
    input  exc_pkg::esc_decision_t decision,
    output exc_pkg::fault_rec_t    pending
);

    logic                                  sel_found;
    logic [$clog2(exc_pkg::num_stages)-1:0] sel_idx;
    exc_pkg::stage_fault_t                 sel;
    logic [31:0]                           sel_fault_eip;
    logic [15:0]                           sel_error_code;

    // ----------------------------------------
    // oldest stage wins
    // ----------------------------------------
    always_comb begin
        sel_found = 1'b0;
        sel_idx   = '0;
        // write down to decode, first hit sticks
        for (int i = exc_pkg::stage_wr; i >= exc_pkg::stage_dec; i--) begin
            if (!sel_found && stage_faults[i].fault) begin
                sel_found = 1'b1;
                sel_idx   = i[$clog2(exc_pkg::num_stages)-1:0];
            end
        end
        sel = stage_faults[sel_idx];
    end

    // pointer correction per stage
    always_comb begin
        case (sel_idx)
            exc_pkg::stage_dec: begin
                // decode has consumed nothing yet
                sel_fault_eip = sel.eip;
            end
            exc_pkg::stage_rd, exc_pkg::stage_exe, exc_pkg::stage_wr: begin
                sel_fault_eip = sel.eip - {28'd0, sel.consumed};
            end
            default: begin
                sel_fault_eip = sel.eip;
            end
        endcase
    end

    // error code filtering
    always_comb begin
        if (sel.vector == exc_pkg::vec_ac) begin
            sel_error_code = 16'd0;
        end else if (sel_idx == exc_pkg::stage_dec && sel.vector != exc_pkg::vec_pf) begin
            // decode gp/ud carry no code
            sel_error_code = 16'd0;
        end else begin
            sel_error_code = sel.error_code;
        end
    end

    // ----------------------------------------
    // pending record
    // ----------------------------------------
    always_ff @(posedge clk) begin
        if (!rst_n) begin
            pending.valid <= 1'b0;
        end else if (decision.to_double) begin
            // same pointers, escalated vector
            pending.vector     <= exc_pkg::vec_df;
            pending.error_code <= 16'd0;
        end else if (decision.deliver || decision.to_shutdown) begin
            pending.valid <= 1'b0;
        end else if (!pending.valid && !decision.halted && sel_found) begin
            pending.vector     <= sel.vector;
            pending.error_code <= sel_error_code;
            pending.fault_eip  <= sel_fault_eip;
            pending.trap_eip   <= sel.eip;
            pending.valid      <= 1'b1;
        end
    end

endmodule

// ==== hdl/fault_escalator.sv ====
/* nesting state and escalation of a pending fault
   decision is combinational on the pending record; only a reset
   leaves shutdown, handler_finished clears nesting */
module fault_escalator (
    input  logic                   clk,
    input  logic                   rst_n,
    input  exc_pkg::fault_rec_t    pending,
    input  logic                   handler_finished,
    output exc_pkg::esc_decision_t decision,
    output logic                   external_bit,
    output logic                   pipe_flush,
    output logic                   shutdown
);

    logic [$clog2(exc_pkg::max_nesting + 2)-1:0] count;
    exc_pkg::fault_class_e                       last_class;
    exc_pkg::fault_class_e                       cur_class;
    logic                                        shutdown_start;
    logic                                        double_start;

    // ----------------------------------------
    // classify the pending vector
    // ----------------------------------------
    always_comb begin
        case (pending.vector)
            exc_pkg::vec_de, exc_pkg::vec_ts, exc_pkg::vec_np,
            exc_pkg::vec_ss, exc_pkg::vec_gp: cur_class = exc_pkg::contributory;
            exc_pkg::vec_pf:                  cur_class = exc_pkg::page_fault;
            exc_pkg::vec_df:                  cur_class = exc_pkg::double_fault;
            // mc, db, bp and friends
            default:                          cur_class = exc_pkg::benign;
        endcase
    end

    assign shutdown_start = (count > exc_pkg::max_nesting) ||
                            (count != '0 && last_class == exc_pkg::double_fault);

    // contributory/page fault pairs that escalate
    assign double_start = count != '0 && cur_class != exc_pkg::double_fault &&
        ((last_class == exc_pkg::contributory && cur_class == exc_pkg::contributory) ||
         (last_class == exc_pkg::page_fault   && cur_class == exc_pkg::contributory) ||
         (last_class == exc_pkg::page_fault   && cur_class == exc_pkg::page_fault));

    always_comb begin
        decision.halted      = shutdown;
        decision.to_shutdown = pending.valid && !shutdown && shutdown_start;
        decision.to_double   = pending.valid && !shutdown && !shutdown_start && double_start;
        decision.deliver     = pending.valid && !shutdown && !shutdown_start && !double_start;
    end

    // flush while pending, forever after shutdown
    assign pipe_flush = pending.valid || shutdown;

    // ----------------------------------------
    // nesting state
    // ----------------------------------------
    always_ff @(posedge clk) begin
        if (!rst_n) begin
            count        <= '0;
            last_class   <= exc_pkg::benign;
            external_bit <= 1'b0;
        end else if (handler_finished) begin
            count        <= '0;
            external_bit <= 1'b0;
        end else if (decision.deliver) begin
            count        <= count + 1'b1;
            last_class   <= cur_class;
            external_bit <= 1'b1;
        end
    end

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            shutdown <= 1'b0;
        end else if (decision.to_shutdown) begin
            shutdown <= 1'b1;
        end
    end

endmodule

// ==== hdl/exc_frame_builder.sv ====
/* formats the frame handed to the delivery microcode
   exc_load is a single-cycle pulse, the microcode must take it;
   exc_frame holds its value until the next delivery */
module exc_frame_builder (
    input  logic                   clk,
    input  logic                   rst_n,
    input  exc_pkg::fault_rec_t    pending,
    input  exc_pkg::esc_decision_t decision,
    input  logic                   external_bit,
    input  logic                   real_mode,
    output logic                   exc_load,
    output exc_pkg::exc_frame_t    exc_frame
);

    logic        is_trap;
    logic        code_whole;
    logic        push_error;
    logic [31:0] frame_eip;
    logic [15:0] frame_error_code;

    // ----------------------------------------
    // frame fields
    // ----------------------------------------
    // traps report the pointer after the instruction
    assign is_trap   = pending.vector == exc_pkg::vec_bp || pending.vector == exc_pkg::vec_of;
    assign frame_eip = is_trap ? pending.trap_eip : pending.fault_eip;

    assign code_whole = pending.vector == exc_pkg::vec_pf || pending.vector == exc_pkg::vec_df;

    always_comb begin
        if (real_mode) begin
            frame_error_code = 16'd0;
        end else if (code_whole) begin
            frame_error_code = pending.error_code;
        end else begin
            // ext bit as it was before this delivery
            frame_error_code = {pending.error_code[15:1], external_bit};
        end
    end

    always_comb begin
        case (pending.vector)
            exc_pkg::vec_df, exc_pkg::vec_ts, exc_pkg::vec_np, exc_pkg::vec_ss,
            exc_pkg::vec_gp, exc_pkg::vec_pf, exc_pkg::vec_ac: push_error = !real_mode;
            default:                                           push_error = 1'b0;
        endcase
    end

    // ----------------------------------------
    // output registers
    // ----------------------------------------
    always_ff @(posedge clk) begin
        if (!rst_n) begin
            exc_load <= 1'b0;
        end else begin
            exc_load <= decision.deliver;
        end
    end

    always_ff @(posedge clk) begin
        if (decision.deliver) begin
            exc_frame.vector     <= pending.vector;
            exc_frame.error_code <= frame_error_code;
            exc_frame.push_error <= push_error;
            exc_frame.eip        <= frame_eip;
        end
    end

endmodule

// ==== hdl/exception_unit.sv ====
/* fault delivery top: arbiter, escalator, frame builder
   two edges from fault to exc_load, three through a double fault */
module exception_unit (
    input  logic                  clk,
    input  logic                  rst_n,
    input  exc_pkg::stage_fault_t stage_faults [exc_pkg::num_stages],
    input  logic                  real_mode,
    input  logic                  handler_finished,
    output logic                  exc_load,
    output exc_pkg::exc_frame_t   exc_frame,
    output logic                  pipe_flush,
    output logic                  shutdown
);

    exc_pkg::fault_rec_t    pending;
    exc_pkg::esc_decision_t decision;
    logic                   external_bit;

    // ----------------------------------------
    fault_arbiter arbiter_i (
        .clk          (clk),
        .rst_n        (rst_n),
        .stage_faults (stage_faults),
        .decision     (decision),
        .pending      (pending)
    );

    fault_escalator escalator_i (
        .clk              (clk),
        .rst_n            (rst_n),
        .pending          (pending),
        .handler_finished (handler_finished),
        .decision         (decision),
        .external_bit     (external_bit),
        .pipe_flush       (pipe_flush),
        .shutdown         (shutdown)
    );

    exc_frame_builder frame_i (
        .clk          (clk),
        .rst_n        (rst_n),
        .pending      (pending),
        .decision     (decision),
        .external_bit (external_bit),
        .real_mode    (real_mode),
        .exc_load     (exc_load),
        .exc_frame    (exc_frame)
    );

endmodule

// ==== bench/exception_unit_props.sv ====
/* output protocol checks, bound into exception_unit
   checks are off while reset is asserted */
module exception_unit_props (
    input logic clk,
    input logic rst_n,
    input logic exc_load,
    input logic pipe_flush,
    input logic shutdown
);

    // read back by the testbench
    int unsigned fail_count = 0;

    // load is a one-cycle pulse
    load_pulse_a: assert property (@(posedge clk) disable iff (!rst_n)
        exc_load |=> !exc_load)
    else begin
        $error("exc_load high for two cycles in a row");
        fail_count++;
    end

    // halted unit delivers nothing
    no_load_halted_a: assert property (@(posedge clk) disable iff (!rst_n)
        $rose(exc_load) |-> !shutdown)
    else begin
        $error("exc_load rose while shutdown was high");
        fail_count++;
    end

    flush_on_shutdown_a: assert property (@(posedge clk) disable iff (!rst_n)
        shutdown |-> pipe_flush)
    else begin
        $error("shutdown high without pipe_flush");
        fail_count++;
    end

endmodule

bind exception_unit exception_unit_props props_i (
    .clk        (clk),
    .rst_n      (rst_n),
    .exc_load   (exc_load),
    .pipe_flush (pipe_flush),
    .shutdown   (shutdown)
);

// ==== bench/exception_unit_tb.sv ====
/* data-driven testbench for the exception unit
   run from the project root, scenarios come from bench/exception_unit_testdata.txt;
   nesting state carries over from one line to the next unless the line asks for
   handler_finished, and every shutdown line ends with a reset */
module exception_unit_tb;

    logic                  clk;
    logic                  rst_n;
    exc_pkg::stage_fault_t stage_faults [exc_pkg::num_stages];
    logic                  real_mode;
    logic                  handler_finished;
    logic                  exc_load;
    exc_pkg::exc_frame_t   exc_frame;
    logic                  pipe_flush;
    logic                  shutdown;

    int checks;
    int mismatches;
    int timeouts;
    int bad_lines;
    int assert_fails;

    exception_unit dut_i (
        .clk              (clk),
        .rst_n            (rst_n),
        .stage_faults     (stage_faults),
        .real_mode        (real_mode),
        .handler_finished (handler_finished),
        .exc_load         (exc_load),
        .exc_frame        (exc_frame),
        .pipe_flush       (pipe_flush),
        .shutdown         (shutdown)
    );

    initial begin
        clk = 1'b0;
        forever #2 clk = ~clk;
    end

    // ----------------------------------------
    // stimulus helpers
    // ----------------------------------------
    task automatic clear_faults();
        for (int i = 0; i < exc_pkg::num_stages; i++) begin
            stage_faults[i] <= '0;
        end
    endtask

    // same record on every masked stage, eip moved 16 bytes per stage
    task automatic drive_faults(input logic [3:0] mask, input exc_pkg::stage_fault_t rec);
        exc_pkg::stage_fault_t staged;
        for (int i = 0; i < exc_pkg::num_stages; i++) begin
            if (mask[i]) begin
                staged          = rec;
                staged.eip      = rec.eip + 32'(i * 16);
                stage_faults[i] <= staged;
            end
        end
    endtask

    task automatic apply_reset();
        @(posedge clk);
        rst_n            <= 1'b0;
        handler_finished <= 1'b0;
        clear_faults();
        repeat (2) @(posedge clk);
        rst_n <= 1'b1;
    endtask

    function automatic void check_field(input string name, input logic [31:0] got,
                                        input logic [31:0] exp);
        checks++;
        if (got !== exp) begin
            mismatches++;
            $display("[FAIL] %0t: %s is %h, expected %h", $time, name, got, exp);
        end
    endfunction

    // edges from the fault edge to the event, seen at a falling edge; -1 on timeout
    task automatic wait_event(input logic want_shutdown, output int edges);
        logic seen;
        seen  = 1'b0;
        edges = 0;
        while (!seen && edges < 20) begin
            @(posedge clk);
            edges++;
            if (edges == 1) begin
                // fault fields last one cycle
                clear_faults();
            end
            @(negedge clk);
            if (edges == 1) begin
                // captured fault flushes the pipe
                checks++;
                if (!pipe_flush) begin
                    mismatches++;
                    $display("[FAIL] %0t: pipe_flush low with a fault pending", $time);
                end
            end
            seen = want_shutdown ? shutdown : exc_load;
        end
        if (!seen) begin
            timeouts++;
            edges = -1;
            $display("timeout: %s did not go high within 20 cycles of the fault",
                     want_shutdown ? "shutdown" : "exc_load");
        end
    endtask

    // halted unit ignores a repeated fault and keeps flushing
    task automatic observe_shutdown(input logic [3:0] mask, input exc_pkg::stage_fault_t rec);
        @(posedge clk);
        drive_faults(mask, rec);
        @(posedge clk);
        clear_faults();
        repeat (6) begin
            @(negedge clk);
            checks++;
            if (exc_load || !pipe_flush || !shutdown) begin
                mismatches++;
                $display("[FAIL] %0t: after shutdown exc_load %b, pipe_flush %b, shutdown %b",
                         $time, exc_load, pipe_flush, shutdown);
            end
        end
    endtask

    // ----------------------------------------
    // scenario loop
    // ----------------------------------------
    initial begin
        int                    fd;
        int                    n;
        string                 line;
        logic [3:0]            mask;
        logic [7:0]            vec;
        logic [15:0]           ec;
        logic [31:0]           eip;
        logic [3:0]            cons;
        int                    rm;
        int                    fin;
        int                    exp_shut;
        logic [7:0]            exp_vec;
        logic [15:0]           exp_ec;
        int                    exp_push;
        logic [31:0]           exp_eip;
        int                    edges;
        int                    exp_edges;
        exc_pkg::stage_fault_t rec;

        checks           = 0;
        mismatches       = 0;
        timeouts         = 0;
        bad_lines        = 0;
        rst_n            <= 1'b0;
        real_mode        <= 1'b0;
        handler_finished <= 1'b0;
        clear_faults();
        repeat (2) @(posedge clk);
        rst_n <= 1'b1;

        fd = $fopen("bench/exception_unit_testdata.txt", "r");
        if (fd == 0) begin
            bad_lines++;
            $display("could not open the scenario file bench/exception_unit_testdata.txt");
        end else begin
            while (!$feof(fd)) begin
                n = $fgets(line, fd);
                // blank lines and comments
                if (n == 0 || line.len() < 2 || line.getc(0) == "#") begin
                    continue;
                end
                n = $sscanf(line, "%h %h %h %h %h %d %d %d %h %h %d %h", mask, vec, ec, eip,
                            cons, rm, fin, exp_shut, exp_vec, exp_ec, exp_push, exp_eip);
                if (n != 12) begin
                    bad_lines++;
                    $display("scenario line could not be parsed: %s", line);
                    continue;
                end
                if (fin != 0) begin
                    @(posedge clk);
                    handler_finished <= 1'b1;
                    @(posedge clk);
                    handler_finished <= 1'b0;
                end
                rec.fault      = 1'b1;
                rec.vector     = vec;
                rec.error_code = ec;
                rec.eip        = eip;
                rec.consumed   = cons;
                @(posedge clk);
                real_mode <= rm[0];
                drive_faults(mask, rec);
                wait_event(exp_shut != 0, edges);
                if (edges < 0) begin
                    // resynchronize after a lost event
                    apply_reset();
                end else if (exp_shut != 0) begin
                    check_field("shutdown latency", edges, 2);
                    observe_shutdown(mask, rec);
                    apply_reset();
                end else begin
                    // escalation through df costs one more edge
                    exp_edges = (exp_vec == exc_pkg::vec_df && vec != exc_pkg::vec_df) ? 3 : 2;
                    check_field("exc_load latency", edges, exp_edges);
                    check_field("vector", exc_frame.vector, exp_vec);
                    check_field("error code", exc_frame.error_code, exp_ec);
                    check_field("push_error", exc_frame.push_error, exp_push);
                    check_field("eip", exc_frame.eip, exp_eip);
                end
            end
            $fclose(fd);
        end

        assert_fails = dut_i.props_i.fail_count;
        $display("checks %0d, mismatches %0d, timeouts %0d, bad lines %0d, assertion fails %0d",
                 checks, mismatches, timeouts, bad_lines, assert_fails);
        if (checks > 0 && mismatches == 0 && timeouts == 0 && bad_lines == 0 &&
            assert_fails == 0) begin
            $display("Testbench passed");
        end else begin
            $display("Testbench failed");
        end
        $finish;
    end

endmodule

// ==== bench/exception_unit_testdata.txt ====
# mask vector error_code eip consumed real_mode finish_first expect(0 deliver, 1 shutdown)
# exp_vector exp_error_code exp_push_error exp_eip   (all hex except the four flag columns)
f 0d 0010 00001000 3 0 0 0 0d 0010 1 0000102d
1 0d 0024 00002000 5 0 1 0 0d 0000 1 00002000
4 11 00ff 00003000 2 0 1 0 11 0000 1 0000301e
2 03 0000 00004000 1 0 1 0 03 0000 0 00004010
8 04 0000 00004100 2 0 0 0 04 0001 0 00004130
8 0d 0042 00005000 4 1 1 0 0d 0000 0 0000502c
2 06 1234 00007000 2 0 1 0 06 1234 0 0000700e
4 0d 0050 00007100 3 0 0 0 0d 0051 1 0000711d
4 0e 0007 00009000 4 0 1 0 0e 0007 1 0000901c
8 0d 0010 0000a000 2 0 0 0 08 0000 1 0000a02e
1 0d 0000 0000b000 0 0 0 1 00 0000 0 00000000
2 0d 0020 0000c000 1 0 0 0 0d 0020 1 0000c00f
8 0e 0005 0000d000 3 0 1 0 0e 0005 1 0000d02d
4 0e 0002 0000e000 2 0 0 0 08 0000 1 0000e01e
8 0d 0010 0000f000 1 0 1 0 0d 0010 1 0000f02f
1 0d 0099 0000f100 2 0 0 0 08 0000 1 0000f100
4 06 0000 00001000 1 0 0 1 00 0000 0 00000000
8 06 0000 00001100 2 0 0 0 06 0000 0 0000112e
1 03 0000 00001200 0 0 0 0 03 0001 0 00001200
2 04 0000 00001300 3 0 0 0 04 0001 0 00001310
8 06 0000 00001400 0 0 0 1 00 0000 0 00000000
6 0c 0030 00002200 4 0 0 0 0c 0030 1 0000221c
3 0a 0041 00002300 1 0 1 0 0a 0040 1 0000230f

// ==== src.f ====
hdl/exc_pkg.sv
hdl/fault_arbiter.sv
hdl/fault_escalator.sv
hdl/exc_frame_builder.sv
hdl/exception_unit.sv
bench/exception_unit_props.sv
bench/exception_unit_tb.sv

// ==== Makefile ====
# Verilator build and run of the exception unit testbench
TOP = exception_unit_tb

.PHONY: all compile run clean

all: run

compile:
	verilator --binary --timing --assert -Wno-fatal --top-module $(TOP) -f src.f -Mdir obj_dir

# pass only if the testbench printed its pass line
run: compile
	@out="$$(./obj_dir/V$(TOP))"; \
	echo "$$out"; \
	echo "$$out" | grep -qx "Testbench passed"

clean:
	rm -rf obj_dir
